// ==== wino_settings.svh ====
`ifndef WINO_SETTINGS_SVH
`define WINO_SETTINGS_SVH

// Element width for Winograd-domain products and every internal sum.
`define WINO_ELEM_W 30

// Quantized output format, bits [FRAC+OUT_W-1:FRAC] of a sum.
`define WINO_OUT_W 16
`define WINO_FRAC 8

// Row FIFO, a power of two.
`define WINO_FIFO_DEPTH 8
`define WINO_LVL_W ($clog2(`WINO_FIFO_DEPTH + 1))

// Wishbone word address width.
`define WINO_WB_AW 3

// Tile geometry for F(4x4,3x3).
`define WINO_TILE_N 6
`define WINO_OUT_N 4

`endif

// ==== wino_pkg.sv ====
`include "wino_settings.svh"

package wino_pkg;

	typedef logic signed [`WINO_ELEM_W-1:0] elem_t;

	typedef logic [`WINO_OUT_W-1:0] out_t;

	// Index c holds column c of the tile row.
	typedef elem_t [`WINO_TILE_N-1:0] row_t;

	typedef enum logic [1:0] {
		INV_COLLECT,
		INV_WAIT,
		INV_DRAIN
	} inv_state_t;

	typedef enum logic [`WINO_WB_AW-1:0] {
		REG_ELEM0 = 3'd0,
		REG_ELEM1 = 3'd1,
		REG_ELEM2 = 3'd2,
		REG_ELEM3 = 3'd3,
		REG_ELEM4 = 3'd4,
		REG_ELEM5 = 3'd5,
		REG_PUSH = 3'd6,
		REG_STATUS = 3'd7 // Read returns the FIFO level.
	} wb_reg_t;

endpackage

// ==== wino_adder_tree.sv ====
`timescale 1ns/1ps

module wino_adder_tree (
	input logic clk,
	input wino_pkg::elem_t i_d0,
	input wino_pkg::elem_t i_d1,
	input wino_pkg::elem_t i_d2,
	input wino_pkg::elem_t i_d3,
	input wino_pkg::elem_t i_d4,
	input wino_pkg::elem_t i_d5,
	output wino_pkg::elem_t o_sum
);

	wino_pkg::elem_t s1_a;
	wino_pkg::elem_t s1_b;
	wino_pkg::elem_t s1_c;
	wino_pkg::elem_t s2_a;
	wino_pkg::elem_t s2_b;

	// Three pairs, then two, then one. All sums wrap at the element width.
	always_ff @(posedge clk) begin
		s1_a <= i_d0 + i_d1;
		s1_b <= i_d2 + i_d3;
		s1_c <= i_d4 + i_d5;

		s2_a <= s1_a + s1_b;
		s2_b <= s1_c; // Balancing stage for the odd pair.

		o_sum <= s2_a + s2_b;
	end

endmodule

// ==== wino_wb_writer.sv ====
`timescale 1ns/1ps
`include "wino_settings.svh"

module wino_wb_writer (
	input logic clk,
	input logic i_rst,
	input logic i_wb_cyc,
	input logic i_wb_stb,
	input logic i_wb_we,
	input logic [`WINO_WB_AW-1:0] i_wb_adr,
	input logic [31:0] i_wb_dat,
	output logic [31:0] o_wb_dat,
	output logic o_wb_ack,
	output logic o_push_valid,
	output wino_pkg::row_t o_push_row,
	input logic i_push_ready,
	input logic [`WINO_LVL_W-1:0] i_level
);

	wino_pkg::wb_reg_t reg_sel;
	wino_pkg::row_t asm_row;
	logic access;

	assign reg_sel = wino_pkg::wb_reg_t'(i_wb_adr);

	// A new access is taken only once the previous ack has gone.
	assign access = i_wb_cyc & i_wb_stb & ~o_wb_ack & ~o_push_valid;

	////////////////////////////////////////////////////////////////////////////
	// Handshake control
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (i_rst) begin
			o_wb_ack <= 1'b0;
			o_push_valid <= 1'b0;
		end else begin
			o_wb_ack <= 1'b0;
			if (o_push_valid) begin
				// PUSH is held open until the FIFO takes the row.
				if (i_push_ready) begin
					o_push_valid <= 1'b0;
					o_wb_ack <= 1'b1;
				end
			end else if (access) begin
				if (i_wb_we && reg_sel == wino_pkg::REG_PUSH) begin
					o_push_valid <= 1'b1;
				end else begin
					o_wb_ack <= 1'b1;
				end
			end
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Row assembly and read data
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (access) begin
			o_wb_dat <= '0;
			if (i_wb_we) begin
				case (reg_sel)
					wino_pkg::REG_ELEM0,
					wino_pkg::REG_ELEM1,
					wino_pkg::REG_ELEM2,
					wino_pkg::REG_ELEM3,
					wino_pkg::REG_ELEM4,
					wino_pkg::REG_ELEM5: begin
						asm_row[i_wb_adr] <= i_wb_dat[`WINO_ELEM_W-1:0];
					end
					wino_pkg::REG_PUSH: begin
						o_push_row <= asm_row; // Copy frees asm_row for the next row.
					end
					default: begin
					end
				endcase
			end else if (reg_sel == wino_pkg::REG_STATUS) begin
				o_wb_dat <= {{(32 - `WINO_LVL_W){1'b0}}, i_level};
			end
		end
	end

endmodule

// ==== wino_row_fifo.sv ====
`timescale 1ns/1ps
`include "wino_settings.svh"

module wino_row_fifo #(
	parameter int DEPTH = `WINO_FIFO_DEPTH
) (
	input logic clk,
	input logic i_rst,
	input logic i_push_valid,
	input wino_pkg::row_t i_push_row,
	output logic o_push_ready,
	output logic o_valid,
	output wino_pkg::row_t o_row,
	input logic i_ready,
	output logic [$clog2(DEPTH + 1)-1:0] o_level
);

	localparam int AW = $clog2(DEPTH);

	wino_pkg::row_t mem [DEPTH];
	logic [AW-1:0] wr_ptr;
	logic [AW-1:0] rd_ptr;
	logic full;
	logic do_push;
	logic do_pop;

	assign full = (o_level == DEPTH);
	assign o_valid = (o_level != '0);
	assign o_row = mem[rd_ptr];

	// A full FIFO still takes a row when one leaves on the same edge.
	assign o_push_ready = ~full | i_ready;

	assign do_push = i_push_valid & o_push_ready;
	assign do_pop = o_valid & i_ready;

	always_ff @(posedge clk) begin
		if (do_push) begin
			mem[wr_ptr] <= i_push_row;
		end
	end

	always_ff @(posedge clk) begin
		if (i_rst) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			o_level <= '0;
		end else begin
			if (do_push) begin
				wr_ptr <= wr_ptr + 1'b1; // Pointers wrap since DEPTH is a power of two.
			end
			if (do_pop) begin
				rd_ptr <= rd_ptr + 1'b1;
			end
			if (do_push && !do_pop) begin
				o_level <= o_level + 1'b1;
			end else if (do_pop && !do_push) begin
				o_level <= o_level - 1'b1;
			end
		end
	end

endmodule

// ==== inverse_winograd.sv ====
`timescale 1ns/1ps
`include "wino_settings.svh"

module inverse_winograd (
	input logic clk,
	input logic i_rst,
	input logic i_valid,
	input wino_pkg::row_t i_row,
	output logic o_ready,
	output logic o_valid,
	output wino_pkg::out_t o_result_0,
	output wino_pkg::out_t o_result_1,
	output wino_pkg::out_t o_result_2,
	output wino_pkg::out_t o_result_3
);

	// Tree inputs for output index k of A^T applied to a six-vector.
	function automatic wino_pkg::row_t at_terms(input wino_pkg::row_t v, input int unsigned k);
		wino_pkg::row_t t;
		t = '0;
		case (k)
			0: begin
				t[0] = v[0];
				t[1] = v[1];
				t[2] = v[2];
				t[3] = v[3];
				t[4] = v[4];
			end
			1: begin
				t[1] = v[1];
				t[2] = -v[2];
				t[3] = v[3] <<< 1;
				t[4] = -(v[4] <<< 1);
			end
			2: begin
				t[1] = v[1];
				t[2] = v[2];
				t[3] = v[3] <<< 2;
				t[4] = v[4] <<< 2;
			end
			default: begin
				t[1] = v[1];
				t[2] = -v[2];
				t[3] = v[3] <<< 3;
				t[4] = -(v[4] <<< 3);
				t[5] = v[5];
			end
		endcase
		return t;
	endfunction

	// ReLU, then keep the integer and fraction bits without saturation.
	function automatic wino_pkg::out_t quantize(input wino_pkg::elem_t s);
		if (s[`WINO_ELEM_W-1]) begin
			return '0;
		end
		return s[`WINO_FRAC +: `WINO_OUT_W];
	endfunction

	wino_pkg::inv_state_t state;
	logic [$clog2(`WINO_TILE_N)-1:0] row_cnt;
	logic [2:0] drain_cnt;
	logic [2:0] rv;
	logic [$clog2(`WINO_TILE_N)-1:0] ridx [3];
	logic [2:0] col_v;
	wino_pkg::elem_t store [`WINO_TILE_N][`WINO_OUT_N];
	wino_pkg::row_t row_terms [`WINO_OUT_N];
	wino_pkg::elem_t row_sum [`WINO_OUT_N];
	wino_pkg::row_t col_vec;
	wino_pkg::row_t col_terms [`WINO_OUT_N];
	wino_pkg::elem_t col_sum [`WINO_OUT_N];

	assign o_ready = (state == wino_pkg::INV_COLLECT);

	//////////////////////////////////////////////////////////////////////////
	// Row pass. Store row r holds (M A)[r][0..3].
	//////////////////////////////////////////////////////////////////////////

	for (genvar g = 0; g < `WINO_OUT_N; g++) begin : g_row_pass
		assign row_terms[g] = at_terms(i_row, g);
		wino_adder_tree u_tree (
			.clk(clk),
			.i_d0(row_terms[g][0]),
			.i_d1(row_terms[g][1]),
			.i_d2(row_terms[g][2]),
			.i_d3(row_terms[g][3]),
			.i_d4(row_terms[g][4]),
			.i_d5(row_terms[g][5]),
			.o_sum(row_sum[g])
		);
	end

	always_ff @(posedge clk) begin
		ridx[0] <= row_cnt;
		ridx[1] <= ridx[0];
		ridx[2] <= ridx[1];
		if (rv[2]) begin
			for (int c = 0; c < `WINO_OUT_N; c++) begin
				store[ridx[2]][c] <= row_sum[c];
			end
		end
	end

	//////////////////////////////////////////////////////////////////////////
	// Control
	//////////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (i_rst) begin
			state <= wino_pkg::INV_COLLECT;
			row_cnt <= '0;
			drain_cnt <= '0;
			rv <= '0;
		end else begin
			rv <= {rv[1:0], i_valid & o_ready};
			case (state)
				wino_pkg::INV_COLLECT: begin
					if (i_valid) begin
						if (row_cnt == `WINO_TILE_N - 1) begin
							row_cnt <= '0;
							state <= wino_pkg::INV_WAIT;
						end else begin
							row_cnt <= row_cnt + 1'b1;
						end
					end
				end
				wino_pkg::INV_WAIT: begin
					if (rv == '0) begin // Sixth row has landed in the store.
						drain_cnt <= '0;
						state <= wino_pkg::INV_DRAIN;
					end
				end
				default: begin
					// Columns go out on counts 0..3, then wait for the last beat.
					drain_cnt <= drain_cnt + 1'b1;
					if (drain_cnt == 3'd7) begin
						state <= wino_pkg::INV_COLLECT;
					end
				end
			endcase
		end
	end

	//////////////////////////////////////////////////////////////////////////
	// Column pass and output stage
	//////////////////////////////////////////////////////////////////////////

	always_comb begin
		for (int r = 0; r < `WINO_TILE_N; r++) begin
			col_vec[r] = store[r][drain_cnt[1:0]];
		end
	end

	for (genvar g = 0; g < `WINO_OUT_N; g++) begin : g_col_pass
		assign col_terms[g] = at_terms(col_vec, g);
		wino_adder_tree u_tree (
			.clk(clk),
			.i_d0(col_terms[g][0]),
			.i_d1(col_terms[g][1]),
			.i_d2(col_terms[g][2]),
			.i_d3(col_terms[g][3]),
			.i_d4(col_terms[g][4]),
			.i_d5(col_terms[g][5]),
			.o_sum(col_sum[g])
		);
	end

	always_ff @(posedge clk) begin
		if (i_rst) begin
			col_v <= '0;
			o_valid <= 1'b0;
		end else begin
			col_v <= {col_v[1:0], (state == wino_pkg::INV_DRAIN) & ~drain_cnt[2]};
			o_valid <= col_v[2]; // Matches the three tree stages.
		end
	end

	always_ff @(posedge clk) begin
		o_result_0 <= quantize(col_sum[0]);
		o_result_1 <= quantize(col_sum[1]);
		o_result_2 <= quantize(col_sum[2]);
		o_result_3 <= quantize(col_sum[3]);
	end

endmodule

// ==== wino_top.sv ====
`timescale 1ns/1ps
`include "wino_settings.svh"

module wino_top (
	input logic clk,
	input logic i_rst,
	input logic i_wb_cyc,
	input logic i_wb_stb,
	input logic i_wb_we,
	input logic [`WINO_WB_AW-1:0] i_wb_adr,
	input logic [31:0] i_wb_dat,
	output logic [31:0] o_wb_dat,
	output logic o_wb_ack,
	output logic o_valid,
	output wino_pkg::out_t o_result_0,
	output wino_pkg::out_t o_result_1,
	output wino_pkg::out_t o_result_2,
	output wino_pkg::out_t o_result_3
);

	logic push_valid;
	logic push_ready;
	wino_pkg::row_t push_row;
	logic row_valid;
	logic row_ready;
	wino_pkg::row_t row;
	logic [`WINO_LVL_W-1:0] level;

	wino_wb_writer u_writer (
		.clk(clk),
		.i_rst(i_rst),
		.i_wb_cyc(i_wb_cyc),
		.i_wb_stb(i_wb_stb),
		.i_wb_we(i_wb_we),
		.i_wb_adr(i_wb_adr),
		.i_wb_dat(i_wb_dat),
		.o_wb_dat(o_wb_dat),
		.o_wb_ack(o_wb_ack),
		.o_push_valid(push_valid),
		.o_push_row(push_row),
		.i_push_ready(push_ready),
		.i_level(level)
	);

	wino_row_fifo #(
		.DEPTH(`WINO_FIFO_DEPTH)
	) u_fifo (
		.clk(clk),
		.i_rst(i_rst),
		.i_push_valid(push_valid),
		.i_push_row(push_row),
		.o_push_ready(push_ready),
		.o_valid(row_valid),
		.o_row(row),
		.i_ready(row_ready),
		.o_level(level)
	);

	inverse_winograd u_inv (
		.clk(clk),
		.i_rst(i_rst),
		.i_valid(row_valid),
		.i_row(row),
		.o_ready(row_ready),
		.o_valid(o_valid),
		.o_result_0(o_result_0),
		.o_result_1(o_result_1),
		.o_result_2(o_result_2),
		.o_result_3(o_result_3)
	);

endmodule

// ==== tb_wino_chk.sv ====
`timescale 1ns/1ps

module tb_wino_chk (
	input logic clk,
	input logic i_rst,
	input logic i_wb_cyc,
	input logic i_wb_stb,
	input logic i_wb_ack,
	input logic i_valid
);

	int unsigned fail_cnt = 0; // Number of assertion failures so far.

	// Classic Wishbone. An ack only answers a live strobe.
	ack_needs_stb: assert property (@(posedge clk) disable iff (i_rst)
		i_wb_ack |-> (i_wb_cyc && i_wb_stb))
		else begin
			$error("Wishbone ack seen without cyc and stb");
			fail_cnt++;
		end

	ack_single: assert property (@(posedge clk) disable iff (i_rst)
		i_wb_ack |=> !i_wb_ack)
		else begin
			$error("Wishbone ack high on two consecutive cycles");
			fail_cnt++;
		end

	valid_after_reset: assert property (@(posedge clk)
		i_rst |=> !i_valid)
		else begin
			$error("Output valid high on the cycle after reset");
			fail_cnt++;
		end

	// One tile leaves as exactly four beats in a row.
	beat_group: assert property (@(posedge clk) disable iff (i_rst)
		$rose(i_valid) |=> i_valid ##1 i_valid ##1 i_valid ##1 !i_valid)
		else begin
			$error("Output valid did not last exactly four cycles");
			fail_cnt++;
		end

endmodule

bind wino_top tb_wino_chk u_chk (
	.clk(clk),
	.i_rst(i_rst),
	.i_wb_cyc(i_wb_cyc),
	.i_wb_stb(i_wb_stb),
	.i_wb_ack(o_wb_ack),
	.i_valid(o_valid)
);

// ==== tb_wino.sv ====
`timescale 1ns/1ps
`include "wino_settings.svh"

module tb_wino;

	localparam int LVL_W = `WINO_LVL_W;
	localparam int N = `WINO_TILE_N;

	logic clk = 1'b0;
	logic i_rst;
	logic i_wb_cyc;
	logic i_wb_stb;
	logic i_wb_we;
	logic [`WINO_WB_AW-1:0] i_wb_adr;
	logic [31:0] i_wb_dat;
	logic [31:0] o_wb_dat;
	logic o_wb_ack;
	logic o_valid;
	wino_pkg::out_t o_result_0;
	wino_pkg::out_t o_result_1;
	wino_pkg::out_t o_result_2;
	wino_pkg::out_t o_result_3;

	int tile [N][N]; // Winograd-domain tile being pushed.
	wino_pkg::out_t exp_q [$]; // Expected results, beat by beat.
	bit [31:0] rng = 32'd80504;
	int beat_total = 0;
	int err_cnt = 0;

	wino_top DUT (.*);

	always #20 clk = ~clk;

	always @(negedge clk) begin
		if (o_valid === 1'b1) begin
			beat_total++;
		end
	end

	always @(DUT.u_chk.fail_cnt) begin
		if (DUT.u_chk.fail_cnt != 0) begin
			$display("A protocol assertion in the bound checker failed at %0t.", $time);
			abort_run();
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Reference model
	////////////////////////////////////////////////////////////////////////////

	function automatic bit [31:0] next_random();
		rng = rng ^ (rng << 13);
		rng = rng ^ (rng >> 17);
		rng = rng ^ (rng << 5);
		return rng;
	endfunction

	function automatic int at_coef(input int g, input int j);
		int row [6];
		case (g)
			0: row = '{1, 1, 1, 1, 1, 0};
			1: row = '{0, 1, -1, 2, -2, 0};
			2: row = '{0, 1, 1, 4, 4, 0};
			default: row = '{0, 1, -1, 8, -8, 1};
		endcase
		return row[j];
	endfunction

	// Y[g][k] = sum over i, j of AT[g][i] * M[i][j] * AT[k][j], wrapped to 30 bits.
	function automatic wino_pkg::out_t model_out(input int g, input int k);
		longint acc;
		logic [`WINO_ELEM_W-1:0] y;
		acc = 0;
		for (int i = 0; i < N; i++) begin
			for (int j = 0; j < N; j++) begin
				acc += longint'(at_coef(g, i)) * tile[i][j] * at_coef(k, j);
			end
		end
		y = acc[`WINO_ELEM_W-1:0];
		if (y[`WINO_ELEM_W-1]) begin
			return '0; // ReLU.
		end
		return y[`WINO_FRAC +: `WINO_OUT_W];
	endfunction

	function automatic void fill_tile(input int kind, input int t);
		bit [31:0] rv;
		for (int r = 0; r < N; r++) begin
			for (int c = 0; c < N; c++) begin
				case (kind)
					0: tile[r][c] = 256 * (r + c + 1);
					1: tile[r][c] = 256 * (r + 1) * (((c == 2) || (c == 4)) ? 40 : 1);
					2: tile[r][c] = 256 * ((r * 7 + c * 3 + t * 5) % 11 + 1);
					default: begin
						rv = next_random();
						tile[r][c] = int'({{2{rv[29]}}, rv[29:0]}); // Full 30-bit range.
					end
				endcase
			end
		end
	endfunction

	////////////////////////////////////////////////////////////////////////////
	// Checks
	////////////////////////////////////////////////////////////////////////////

	task automatic abort_run();
		$display("Checks failed");
		$fatal(1, "Simulation stopped at the first error.");
	endtask

	task automatic check_out(input wino_pkg::out_t expv, input wino_pkg::out_t got,
			input int beat, input int g);
		if (got !== expv) begin
			err_cnt++;
			$display("ERR %0t: beat %0d result_%0d expected %h got %h",
				$time, beat, g, expv, got);
			abort_run();
		end
	endtask

	// The level comes back zero-extended to the full data bus.
	task automatic check_status(input logic [LVL_W-1:0] expv, input logic [31:0] got);
		if (got !== 32'(expv)) begin
			err_cnt++;
			$display("ERR %0t: FIFO level expected %0d got %0d", $time, expv, got);
			abort_run();
		end
	endtask

	task automatic check_beats(input int expv, input int got);
		if (got != expv) begin
			err_cnt++;
			$display("ERR %0t: output beat count expected %0d got %0d", $time, expv, got);
			abort_run();
		end
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Wishbone and tile traffic
	////////////////////////////////////////////////////////////////////////////

	task automatic wait_ack();
		int waited;
		waited = 0;
		do begin
			@(negedge clk);
			waited++;
			if (waited > 200) begin
				$display("Timeout: no Wishbone ack within 200 cycles.");
				abort_run();
			end
		end while (o_wb_ack !== 1'b1);
		@(negedge clk); // Strobe stays up through the edge that samples ack.
		i_wb_cyc = 1'b0;
		i_wb_stb = 1'b0;
	endtask

	task automatic wb_write(input logic [`WINO_WB_AW-1:0] adr, input logic [31:0] dat);
		i_wb_we = 1'b1;
		i_wb_adr = adr;
		i_wb_dat = dat;
		i_wb_cyc = 1'b1;
		i_wb_stb = 1'b1;
		wait_ack();
	endtask

	task automatic wb_read(input logic [`WINO_WB_AW-1:0] adr, output logic [31:0] dat);
		i_wb_we = 1'b0;
		i_wb_adr = adr;
		i_wb_cyc = 1'b1;
		i_wb_stb = 1'b1;
		wait_ack();
		dat = o_wb_dat; // Held until the next access.
	endtask

	task automatic expect_tile();
		for (int k = 0; k < `WINO_OUT_N; k++) begin
			for (int g = 0; g < `WINO_OUT_N; g++) begin
				exp_q.push_back(model_out(g, k));
			end
		end
	endtask

	task automatic push_row(input int r);
		for (int c = 0; c < N; c++) begin
			wb_write(`WINO_WB_AW'(c), 32'(tile[r][c]));
		end
		wb_write(wino_pkg::REG_PUSH, 32'd0);
	endtask

	task automatic push_tile();
		expect_tile();
		for (int r = 0; r < N; r++) begin
			push_row(r);
		end
	endtask

	task automatic collect_tile();
		int waited;
		for (int b = 0; b < `WINO_OUT_N; b++) begin
			waited = 0;
			do begin
				@(negedge clk);
				waited++;
				if (waited > 400) begin
					$display("Timeout: output beat %0d did not arrive within 400 cycles.", b);
					abort_run();
				end
			end while (o_valid !== 1'b1);
			check_out(exp_q.pop_front(), o_result_0, b, 0);
			check_out(exp_q.pop_front(), o_result_1, b, 1);
			check_out(exp_q.pop_front(), o_result_2, b, 2);
			check_out(exp_q.pop_front(), o_result_3, b, 3);
		end
	endtask

	// Beats have no back-pressure, so the collector runs beside the host.
	task automatic run_tiles(input int kind, input int n);
		fork
			for (int t = 0; t < n; t++) begin
				fill_tile(kind, t);
				push_tile();
			end
			for (int t = 0; t < n; t++) begin
				collect_tile();
			end
		join
	endtask

	task automatic check_idle(input int beats);
		logic [31:0] rdat;
		wb_read(wino_pkg::REG_STATUS, rdat);
		check_status('0, rdat);
		check_beats(beats, beat_total);
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Tests
	////////////////////////////////////////////////////////////////////////////

	task automatic test_reset_status();
		logic [31:0] rdat;
		check_beats(0, beat_total);
		wb_read(wino_pkg::REG_STATUS, rdat);
		check_status('0, rdat);
		fill_tile(2, 3);
		expect_tile();
		push_row(0);
		wb_read(wino_pkg::REG_STATUS, rdat);
		if (rdat !== 32'd0) begin
			check_status(LVL_W'(1), rdat); // The transform pops a lone row at once.
		end
		fork
			for (int r = 1; r < N; r++) begin
				push_row(r);
			end
			collect_tile();
		join
		check_idle(4);
	endtask

	task automatic test_known_tile();
		run_tiles(0, 1);
		check_idle(8);
	endtask

	task automatic test_relu();
		run_tiles(1, 1);
		check_idle(12);
	endtask

	task automatic test_back_pressure();
		run_tiles(2, 3);
		check_idle(24);
	endtask

	task automatic test_random_wrap();
		run_tiles(3, 4);
		check_idle(40);
	endtask

	initial begin
		i_rst = 1'b1;
		i_wb_cyc = 1'b0;
		i_wb_stb = 1'b0;
		i_wb_we = 1'b0;
		i_wb_adr = '0;
		i_wb_dat = '0;
		repeat (3) @(negedge clk);
		i_rst = 1'b0;

		test_reset_status();
		test_known_tile();
		test_relu();
		test_back_pressure();
		test_random_wrap();

		if (err_cnt == 0 && DUT.u_chk.fail_cnt == 0) begin
			$display("All checks passed");
			$finish;
		end else begin
			abort_run();
		end
	end

endmodule

// ==== wino_inv.f ====
+incdir+.
wino_pkg.sv
wino_adder_tree.sv
wino_wb_writer.sv
wino_row_fifo.sv
inverse_winograd.sv
wino_top.sv
tb_wino_chk.sv
tb_wino.sv
